// ==== all.f ====
+incdir+tb
source/ppu_pkg.sv
source/ppu_regs.sv
source/ppu_timing.sv
source/bg_fetcher.sv
source/ppu_top.sv
tb/ppu_assert.sv
tb/ppu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it
# the log is searched for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module ppu_tb -f all.f -o ppu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# keep running after assertion errors so the summary is printed
./obj_dir/ppu_sim +verilator+error+limit+100000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test passed" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0

// ==== source/bg_fetcher.sv ====
// background tile fetch of the lcd block
// three vram reads per tile: map entry, low plane, high plane
// coarse scroll in the address, fine scroll by dropping pixels
// pixel shifter and BGP palette lookup

`timescale 1ns/1ps

module bg_fetcher (
	input logic clk,
	input logic reset,

	input logic [7:0] lcdc,
	input logic [7:0] bgp,
	input logic [8:0] h_cnt,
	input logic [7:0] v_cnt,
	input logic [7:0] scx_line,
	input logic [7:0] scy_line,

	// video ram
	output logic vram_rd,
	output ppu_pkg::vram_addr_t vram_addr,
	input logic [7:0] vram_data,

	// lcd
	output logic lcd_clkena,
	output logic [1:0] lcd_data
);

	// fetch runs over 21 groups of 8 dots after oam scan
	localparam int FETCH_END = ppu_pkg::OAM_LEN + 8 * ppu_pkg::FETCH_TILES;

	logic visible;
	logic fetch_active;
	logic [8:0] fetch_off;
	logic [7:0] bg_line;
	logic [1:0] slot;
	logic [8:0] pix_idx;
	logic [8:0] fine;
	logic [1:0] color;

	// fetched tile, payload only
	logic [7:0] tile_num;
	logic [7:0] plane_lo;
	logic [7:0] plane_hi;
	logic [7:0] shift_lo;
	logic [7:0] shift_hi;

	assign visible = (v_cnt < 8'(ppu_pkg::VISIBLE_LINES));
	assign fetch_active = visible && (h_cnt >= 9'(ppu_pkg::OAM_LEN)) &&
		(h_cnt < 9'(FETCH_END));

	// dot within the fetch, bits 7:3 are the tile index
	assign fetch_off = h_cnt - 9'(ppu_pkg::OAM_LEN);
	// two dot slot within the group of 8
	assign slot = h_cnt[2:1];

	// background line including vertical scroll
	assign bg_line = v_cnt + scy_line;

	// --------------------
	// vram access
	// slot 3 is idle
	assign vram_rd = fetch_active && (slot != 2'b11);

	always_comb begin
		vram_addr = '0;
		if (slot == 2'b00) begin
			vram_addr.map.base = 2'b11;
			vram_addr.map.map_sel = lcdc[3];
			vram_addr.map.row = bg_line[7:3];
			// coarse scroll, wraps around the 32 tile map
			vram_addr.map.col = scx_line[7:3] + fetch_off[7:3];
		end else begin
			// signed tile numbers from 0x9000 when LCDC bit 4 is clear
			vram_addr.data.a12 = lcdc[4] ? 1'b0 : ~tile_num[7];
			vram_addr.data.tile = tile_num;
			vram_addr.data.line = bg_line[2:0];
			// slot 1 reads the low plane, slot 2 the high plane
			vram_addr.data.plane = h_cnt[2];
		end
	end

	// data is sampled on the second dot of each slot
	always_ff @(posedge clk) begin
		if (fetch_active && h_cnt[0]) begin
			case (slot)
				2'b00: tile_num <= vram_data;
				2'b01: plane_lo <= vram_data;
				2'b10: plane_hi <= vram_data;
				default: begin
					// idle slot
				end
			endcase
		end
	end

	// --------------------
	// pixel shifter
	// load on the last dot of the group, shift msb first otherwise
	always_ff @(posedge clk) begin
		if (fetch_active && (h_cnt[2:0] == 3'd7)) begin
			shift_lo <= plane_lo;
			shift_hi <= plane_hi;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end
	end

	// index of the pixel leaving the shifter
	assign pix_idx = h_cnt - 9'(ppu_pkg::PIXEL_START);
	assign fine = {6'd0, scx_line[2:0]};

	// the first scx mod 8 pixels are dropped
	assign lcd_clkena = visible && (h_cnt >= 9'(ppu_pkg::PIXEL_START)) &&
		(pix_idx >= fine) && (pix_idx < fine + 9'(ppu_pkg::SCREEN_WIDTH));

	// --------------------
	// palette
	assign color = {shift_hi[7], shift_lo[7]};

	// background off gives colour 0 shade white
	always_comb begin
		if (!lcdc[0] || reset) begin
			lcd_data = 2'b00;
		end else begin
			lcd_data = bgp[2 * color +: 2];
		end
	end

endmodule

// ==== source/ppu_pkg.sv ====
// shared definitions for the background picture unit
// line and frame timing constants
// cpu register addresses of the lcd block
// vram address union with tile map and tile data views

package ppu_pkg;

	// --------------------
	// line and frame timing
	// dots per line, including hblank
	localparam int LINE_CLOCKS = 456;
	// lines with picture output
	localparam int VISIBLE_LINES = 144;
	// length of mode 2 at the start of a line
	localparam int OAM_LEN = 80;
	// first dot of hblank, mode 3 has a fixed length
	localparam int DRAW_END = 256;
	// tiles fetched on every visible line
	localparam int FETCH_TILES = 21;
	localparam int SCREEN_WIDTH = 160;
	// first dot at which a pixel leaves the shifter
	localparam int PIXEL_START = 88;

	// --------------------
	// register addresses, low byte of 0xff4x
	localparam logic [7:0] REG_LCDC = 8'h40;
	localparam logic [7:0] REG_STAT = 8'h41;
	localparam logic [7:0] REG_SCY = 8'h42;
	localparam logic [7:0] REG_SCX = 8'h43;
	localparam logic [7:0] REG_LY = 8'h44;
	localparam logic [7:0] REG_LYC = 8'h45;
	localparam logic [7:0] REG_BGP = 8'h47;

	// --------------------
	// tile map entry, base is always 2'b11 (0x1800 or 0x1c00)
	typedef struct packed {
		logic [1:0] base;
		logic map_sel;
		logic [4:0] row;
		logic [4:0] col;
	} vram_map_addr_t;

	// one plane byte of one line of a tile
	typedef struct packed {
		logic a12;
		logic [7:0] tile;
		logic [2:0] line;
		logic plane;
	} vram_data_addr_t;

	typedef union packed {
		vram_map_addr_t map;
		vram_data_addr_t data;
	} vram_addr_t;

endpackage

// ==== source/ppu_regs.sv ====
// cpu register file of the lcd block
// LCDC, STAT, SCY, SCX, LY, LYC and BGP
// write strobe with select, combinational read multiplexer
// STAT coincidence bit from LY and LYC

`timescale 1ns/1ps

module ppu_regs (
	input logic clk,
	input logic reset,

	// cpu side
	input logic cpu_sel_reg,
	input logic cpu_wr,
	input logic [7:0] cpu_addr,
	input logic [7:0] cpu_di,
	output logic [7:0] cpu_do,

	// state from the timing unit
	input logic [7:0] v_cnt,
	input logic [1:0] mode,

	// register contents to the other units
	output logic [7:0] lcdc,
	output logic [3:0] stat_ena,
	output logic [7:0] scy,
	output logic [7:0] scx,
	output logic [7:0] lyc,
	output logic [7:0] bgp
);

	logic wr_en;
	logic lyc_match;

	assign wr_en = cpu_sel_reg && cpu_wr;

	// coincidence flag as seen by the cpu
	assign lyc_match = (v_cnt == lyc);

	// --------------------
	// register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			// lcd starts switched off
			lcdc <= 8'h00;
			stat_ena <= 4'h0;
			scy <= 8'h00;
			scx <= 8'h00;
			lyc <= 8'h00;
			// darkest shade for colours 3..1, white for 0
			bgp <= 8'hfc;
		end else if (wr_en) begin
			case (cpu_addr)
				ppu_pkg::REG_LCDC: begin
					lcdc <= cpu_di;
				end
				ppu_pkg::REG_STAT: begin
					// only the interrupt enables are writable
					stat_ena <= cpu_di[6:3];
				end
				ppu_pkg::REG_SCY: begin
					scy <= cpu_di;
				end
				ppu_pkg::REG_SCX: begin
					scx <= cpu_di;
				end
				ppu_pkg::REG_LYC: begin
					lyc <= cpu_di;
				end
				ppu_pkg::REG_BGP: begin
					bgp <= cpu_di;
				end
				default: begin
					// LY and unmapped addresses drop the write
				end
			endcase
		end
	end

	// --------------------
	// read multiplexer
	always_comb begin
		case (cpu_addr)
			ppu_pkg::REG_LCDC: cpu_do = lcdc;
			// bit 7 reads as one
			ppu_pkg::REG_STAT: cpu_do = {1'b1, stat_ena, lyc_match, mode};
			ppu_pkg::REG_SCY: cpu_do = scy;
			ppu_pkg::REG_SCX: cpu_do = scx;
			// current line straight from the counter
			ppu_pkg::REG_LY: cpu_do = v_cnt;
			ppu_pkg::REG_LYC: cpu_do = lyc;
			ppu_pkg::REG_BGP: cpu_do = bgp;
			// open bus
			default: cpu_do = 8'hff;
		endcase
	end

endmodule

// ==== source/ppu_timing.sv ====
// dot and line counters of the lcd block
// display mode decode
// per line latch of the scroll registers
// STAT interrupt sources, registered one cycle pulse

`timescale 1ns/1ps

module ppu_timing #(
	parameter int VBLANK_LINES = 10
) (
	input logic clk,
	input logic reset,

	input logic lcdc_on,
	input logic [3:0] stat_ena,
	input logic [7:0] lyc,
	input logic [7:0] scx,
	input logic [7:0] scy,

	output logic [8:0] h_cnt,
	output logic [7:0] v_cnt,
	output logic [1:0] mode,
	output logic [7:0] scx_line,
	output logic [7:0] scy_line,
	output logic irq
);

	// last line of the frame, end of vblank
	localparam int LAST_LINE = ppu_pkg::VISIBLE_LINES + VBLANK_LINES - 1;

	logic line_end;
	logic vblank;
	logic lyc_match;
	logic irq_oam;
	logic irq_lyc;
	logic irq_vblank;
	logic irq_hblank;

	assign line_end = (h_cnt == 9'(ppu_pkg::LINE_CLOCKS - 1));
	assign vblank = (v_cnt >= 8'(ppu_pkg::VISIBLE_LINES));
	assign lyc_match = (v_cnt == lyc);

	// --------------------
	// counters
	// both held at zero while the lcd is off
	always_ff @(posedge clk) begin
		if (reset || !lcdc_on) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			if (v_cnt == 8'(LAST_LINE)) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 8'd1;
			end
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// mode 1 vblank, 2 oam scan, 3 drawing, 0 hblank
	always_comb begin
		if (!lcdc_on) begin
			mode = 2'd0;
		end else if (vblank) begin
			mode = 2'd1;
		end else if (h_cnt < 9'(ppu_pkg::OAM_LEN)) begin
			mode = 2'd2;
		end else if (h_cnt < 9'(ppu_pkg::DRAW_END)) begin
			mode = 2'd3;
		end else begin
			mode = 2'd0;
		end
	end

	// scroll stays fixed for the rest of the line
	// latched one dot before the fetch starts
	always_ff @(posedge clk) begin
		if (h_cnt == 9'(ppu_pkg::OAM_LEN - 1)) begin
			scx_line <= scx;
			scy_line <= scy;
		end
	end

	// --------------------
	// STAT interrupt sources
	// stat_ena[3] is STAT bit 6, stat_ena[0] is STAT bit 3
	assign irq_lyc = stat_ena[3] && (h_cnt == 9'd1) && lyc_match;
	assign irq_oam = stat_ena[2] && (h_cnt == 9'd0);
	assign irq_vblank = stat_ena[1] && line_end &&
		(v_cnt == 8'(ppu_pkg::VISIBLE_LINES - 1));
	assign irq_hblank = stat_ena[0] && !vblank &&
		(h_cnt == 9'(ppu_pkg::DRAW_END));

	// counters sit at zero when off, so mask by lcdc_on
	always_ff @(posedge clk) begin
		if (reset) begin
			irq <= 1'b0;
		end else begin
			irq <= lcdc_on && (irq_lyc || irq_oam || irq_vblank || irq_hblank);
		end
	end

endmodule

// ==== source/ppu_top.sv ====
// top level of the background picture unit
// cpu register file, line timing and tile fetcher

`timescale 1ns/1ps

module ppu_top #(
	parameter int VBLANK_LINES = 10
) (
	input logic clk,
	input logic reset,

	// cpu register interface
	input logic cpu_sel_reg,
	input logic cpu_wr,
	input logic [7:0] cpu_addr,
	input logic [7:0] cpu_di,
	output logic [7:0] cpu_do,

	// lcd
	output logic lcd_on,
	output logic lcd_clkena,
	output logic [1:0] lcd_data,
	output logic irq,
	output logic [1:0] mode,

	// video ram
	output logic vram_rd,
	output logic [12:0] vram_addr,
	input logic [7:0] vram_data
);

	// register contents
	logic [7:0] lcdc;
	logic [3:0] stat_ena;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;

	// timing state
	logic [8:0] h_cnt;
	logic [7:0] v_cnt;
	logic [7:0] scx_line;
	logic [7:0] scy_line;

	assign lcd_on = lcdc[7];

	ppu_regs u_regs (
		.clk(clk),
		.reset(reset),
		.cpu_sel_reg(cpu_sel_reg),
		.cpu_wr(cpu_wr),
		.cpu_addr(cpu_addr),
		.cpu_di(cpu_di),
		.cpu_do(cpu_do),
		.v_cnt(v_cnt),
		.mode(mode),
		.lcdc(lcdc),
		.stat_ena(stat_ena),
		.scy(scy),
		.scx(scx),
		.lyc(lyc),
		.bgp(bgp)
	);

	ppu_timing #(
		.VBLANK_LINES(VBLANK_LINES)
	) u_timing (
		.clk(clk),
		.reset(reset),
		.lcdc_on(lcdc[7]),
		.stat_ena(stat_ena),
		.lyc(lyc),
		.scx(scx),
		.scy(scy),
		.h_cnt(h_cnt),
		.v_cnt(v_cnt),
		.mode(mode),
		.scx_line(scx_line),
		.scy_line(scy_line),
		.irq(irq)
	);

	bg_fetcher u_fetcher (
		.clk(clk),
		.reset(reset),
		.lcdc(lcdc),
		.bgp(bgp),
		.h_cnt(h_cnt),
		.v_cnt(v_cnt),
		.scx_line(scx_line),
		.scy_line(scy_line),
		.vram_rd(vram_rd),
		.vram_addr(vram_addr),
		.vram_data(vram_data),
		.lcd_clkena(lcd_clkena),
		.lcd_data(lcd_data)
	);

endmodule

// ==== tb/vram_pattern.svh ====
// video ram content for the testbench
// every byte is a fixed mix of all 13 address bits
// used by the vram model and by the bound checker

// byte stored at a vram address
function automatic logic [7:0] vram_pattern(input logic [12:0] addr);
	logic [7:0] mix;
	// fold the upper address bits into the low byte
	mix = addr[7:0] ^ {addr[12:8], addr[12:10]};
	return (mix * 8'd29) + {addr[3:0], addr[11:8]};
endfunction

// ==== tb/ppu_assert.sv ====
// checker bound into the picture unit top level
// reference dot and line counters, mode and interrupt model
// expected vram addresses and pixels from the pattern function
// concurrent assertions with a failure counter

`timescale 1ns/1ps

module ppu_assert #(
	parameter int VBLANK_LINES = 10
) (
	input logic clk,
	input logic reset,
	input logic [7:0] cpu_addr,
	input logic [7:0] cpu_do,
	input logic [7:0] lcdc,
	input logic [3:0] stat_ena,
	input logic [7:0] lyc,
	input logic [7:0] scx,
	input logic [7:0] scy,
	input logic [7:0] bgp,
	input logic [8:0] h_cnt,
	input logic [7:0] v_cnt,
	input logic [1:0] mode,
	input logic irq,
	input logic vram_rd,
	input logic [12:0] vram_addr,
	input logic lcd_clkena,
	input logic [1:0] lcd_data
);

	localparam logic [7:0] LAST_LINE = 8'(ppu_pkg::VISIBLE_LINES + VBLANK_LINES - 1);

	int fail_count = 0;

	logic [8:0] ref_h;
	logic [7:0] ref_v;
	logic [7:0] ref_scx;
	logic [7:0] ref_scy;
	logic [8:0] ena_count;
	logic was_on;
	logic exp_irq;
	logic trig;
	logic on_line;
	logic [8:0] dot_off;
	logic [8:0] pix;
	logic [7:0] bg_y;
	logic [11:0] fetch_line;
	logic [11:0] pix_line;
	logic [7:0] lo;
	logic [7:0] hi;
	logic [1:0] color;
	logic [1:0] exp_mode;
	logic exp_rd;
	logic exp_ena;
	logic [12:0] exp_addr;
	logic [1:0] exp_data;

	`include "vram_pattern.svh"

	// a12, tile number and tile line of tile t on background line y
	function automatic logic [11:0] tile_line(input logic [4:0] t, input logic [7:0] y,
		input logic [7:0] sx, input logic map_sel, input logic unsigned_data);
		logic [12:0] map_addr;
		logic [7:0] tile;
		map_addr = {2'b11, map_sel, y[7:3], sx[7:3] + t};
		tile = vram_pattern(map_addr);
		return {unsigned_data ? 1'b0 : ~tile[7], tile, y[2:0]};
	endfunction

	// --------------------
	// reference counters idle at zero while the lcd is off
	always_ff @(posedge clk) begin
		if (reset || !lcdc[7]) begin
			ref_h <= '0;
			ref_v <= '0;
			ena_count <= '0;
		end else if (ref_h == 9'd455) begin
			ref_h <= '0;
			ref_v <= (ref_v == LAST_LINE) ? 8'd0 : ref_v + 8'd1;
			ena_count <= '0;
		end else begin
			ref_h <= ref_h + 9'd1;
			ena_count <= ena_count + 9'(lcd_clkena);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ref_scx <= '0;
			ref_scy <= '0;
			was_on <= 1'b0;
			exp_irq <= 1'b0;
		end else begin
			// scroll taken at dot 79
			if (ref_h == 9'd79) begin
				ref_scx <= scx;
				ref_scy <= scy;
			end
			was_on <= lcdc[7];
			exp_irq <= trig;
		end
	end

	always_comb begin
		on_line = lcdc[7] && (ref_v < 8'd144);
		dot_off = ref_h - 9'd80;
		pix = ref_h - 9'd88;
		bg_y = ref_v + ref_scy;
		if (!lcdc[7]) exp_mode = 2'd0;
		else if (ref_v >= 8'd144) exp_mode = 2'd1;
		else if (ref_h < 9'd80) exp_mode = 2'd2;
		else if (ref_h < 9'd256) exp_mode = 2'd3;
		else exp_mode = 2'd0;
		// oam, lyc, vblank and hblank sources
		trig = lcdc[7] && ((stat_ena[2] && ref_h == 9'd0) ||
			(stat_ena[3] && ref_h == 9'd1 && ref_v == lyc) ||
			(stat_ena[1] && ref_h == 9'd455 && ref_v == 8'd143) ||
			(stat_ena[0] && ref_h == 9'd256 && ref_v < 8'd144));
		// fetch of 21 tiles with map then low plane then high plane
		exp_rd = on_line && ref_h >= 9'd80 && ref_h < 9'd248 && dot_off[2:0] < 3'd6;
		fetch_line = tile_line(dot_off[7:3], bg_y, ref_scx, lcdc[3], lcdc[4]);
		if (dot_off[2:1] == 2'd0) begin
			exp_addr = {2'b11, lcdc[3], bg_y[7:3], ref_scx[7:3] + dot_off[7:3]};
		end else begin
			exp_addr = {fetch_line, dot_off[2]};
		end
		// pixel i at dot 88+i with the msb of each plane byte first
		pix_line = tile_line(pix[7:3], bg_y, ref_scx, lcdc[3], lcdc[4]);
		lo = vram_pattern({pix_line, 1'b0});
		hi = vram_pattern({pix_line, 1'b1});
		color = {hi[3'd7 - pix[2:0]], lo[3'd7 - pix[2:0]]};
		case (color)
			2'd0: exp_data = bgp[1:0];
			2'd1: exp_data = bgp[3:2];
			2'd2: exp_data = bgp[5:4];
			default: exp_data = bgp[7:6];
		endcase
		if (!lcdc[0]) exp_data = 2'd0;
		exp_ena = on_line && ref_h >= 9'd88 && pix >= {6'd0, ref_scx[2:0]} &&
			pix < {6'd0, ref_scx[2:0]} + 9'd160;
	end

	// --------------------
	a_counters: assert property (@(posedge clk) disable iff (reset)
		h_cnt == ref_h && v_cnt == ref_v)
		else begin
			$error("MISMATCH h_cnt/v_cnt: got %h/%h, expected %h/%h",
				h_cnt, v_cnt, ref_h, ref_v);
			fail_count = fail_count + 1;
		end

	a_mode: assert property (@(posedge clk) disable iff (reset) mode == exp_mode)
		else begin
			$error("MISMATCH mode: got %h, expected %h", mode, exp_mode);
			fail_count = fail_count + 1;
		end

	a_lcd_off: assert property (@(posedge clk) disable iff (reset)
		(!lcdc[7] && !was_on) |-> (mode == 2'd0 && v_cnt == 8'd0 && !vram_rd &&
		!lcd_clkena && !irq))
		else begin
			$error("activity while the lcd is off");
			fail_count = fail_count + 1;
		end

	a_vram_rd: assert property (@(posedge clk) disable iff (reset) vram_rd == exp_rd)
		else begin
			$error("MISMATCH vram_rd at dot %0d: got %h, expected %h", ref_h, vram_rd, exp_rd);
			fail_count = fail_count + 1;
		end

	a_vram_addr: assert property (@(posedge clk) disable iff (reset)
		vram_rd |-> vram_addr == exp_addr)
		else begin
			$error("MISMATCH vram_addr: got %h, expected %h", vram_addr, exp_addr);
			fail_count = fail_count + 1;
		end

	a_clkena: assert property (@(posedge clk) disable iff (reset) lcd_clkena == exp_ena)
		else begin
			$error("MISMATCH lcd_clkena at dot %0d: got %h, expected %h",
				ref_h, lcd_clkena, exp_ena);
			fail_count = fail_count + 1;
		end

	a_pixel: assert property (@(posedge clk) disable iff (reset)
		lcd_clkena |-> lcd_data == exp_data)
		else begin
			$error("MISMATCH lcd_data at dot %0d: got %h, expected %h",
				ref_h, lcd_data, exp_data);
			fail_count = fail_count + 1;
		end

	// 160 enables on a visible line and none in vblank
	a_line_count: assert property (@(posedge clk) disable iff (reset)
		(lcdc[7] && ref_h == 9'd455) |-> ena_count == (ref_v < 8'd144 ? 9'd160 : 9'd0))
		else begin
			$error("line %0d had %0d pixel enables", ref_v, ena_count);
			fail_count = fail_count + 1;
		end

	a_irq: assert property (@(posedge clk) disable iff (reset) irq == exp_irq)
		else begin
			$error("MISMATCH irq at dot %0d line %0d: got %h, expected %h",
				ref_h, ref_v, irq, exp_irq);
			fail_count = fail_count + 1;
		end

	a_stat_read: assert property (@(posedge clk) disable iff (reset)
		cpu_addr == ppu_pkg::REG_STAT |->
		cpu_do == {1'b1, stat_ena, ref_v == lyc, exp_mode})
		else begin
			$error("MISMATCH cpu_do (STAT): got %h, expected %h",
				cpu_do, {1'b1, stat_ena, ref_v == lyc, exp_mode});
			fail_count = fail_count + 1;
		end

endmodule

bind ppu_top ppu_assert #(
	.VBLANK_LINES(VBLANK_LINES)
) u_assert (
	.clk(clk),
	.reset(reset),
	.cpu_addr(cpu_addr),
	.cpu_do(cpu_do),
	.lcdc(lcdc),
	.stat_ena(stat_ena),
	.lyc(lyc),
	.scx(scx),
	.scy(scy),
	.bgp(bgp),
	.h_cnt(h_cnt),
	.v_cnt(v_cnt),
	.mode(mode),
	.irq(irq),
	.vram_rd(vram_rd),
	.vram_addr(vram_addr),
	.lcd_clkena(lcd_clkena),
	.lcd_data(lcd_data)
);

// ==== tb/ppu_tb.sv ====
// testbench top of the background picture unit
// clock, reset, vram model and register stimulus
// register read-back checks, per test report and timeout

`timescale 1ns/1ps

module ppu_tb;

	// two full frames of 70224 cycles plus the short tests and a margin
	localparam int MAX_CYCLES = 250000;

	logic clk;
	logic reset;
	logic cpu_sel_reg;
	logic cpu_wr;
	logic [7:0] cpu_addr;
	logic [7:0] cpu_di;
	logic [7:0] cpu_do;
	logic lcd_on;
	logic lcd_clkena;
	logic [1:0] lcd_data;
	logic irq;
	logic [1:0] mode;
	logic vram_rd;
	logic [12:0] vram_addr;
	logic [7:0] vram_data;

	int cycles = 0;
	int checks = 0;
	int mismatches = 0;
	// errors counted up to the end of the previous test
	int seen_errors = 0;

	`include "vram_pattern.svh"

	// vram answers within the same two dot slot
	assign vram_data = vram_pattern(vram_addr);

	ppu_top dut (
		.clk(clk),
		.reset(reset),
		.cpu_sel_reg(cpu_sel_reg),
		.cpu_wr(cpu_wr),
		.cpu_addr(cpu_addr),
		.cpu_di(cpu_di),
		.cpu_do(cpu_do),
		.lcd_on(lcd_on),
		.lcd_clkena(lcd_clkena),
		.lcd_data(lcd_data),
		.irq(irq),
		.mode(mode),
		.vram_rd(vram_rd),
		.vram_addr(vram_addr),
		.vram_data(vram_data)
	);

	always #4 clk = ~clk;

	// --------------------
	// timeout
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: display did not advance within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// one cpu write and the address parked on STAT afterwards
	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu_sel_reg = 1'b1;
		cpu_wr = 1'b1;
		cpu_addr = addr;
		cpu_di = data;
		@(negedge clk);
		cpu_sel_reg = 1'b0;
		cpu_wr = 1'b0;
		cpu_addr = ppu_pkg::REG_STAT;
		// lcd_on follows LCDC bit 7 from the write edge on
		if (addr == ppu_pkg::REG_LCDC) begin
			checks++;
			if (lcd_on !== data[7]) begin
				$display("MISMATCH lcd_on: got %h, expected %h", lcd_on, data[7]);
				mismatches++;
			end
		end
	endtask

	// combinational read sampled in the middle of the low phase
	task automatic check_reg(input logic [7:0] addr, input logic [7:0] exp, input string name);
		@(negedge clk);
		cpu_addr = addr;
		#2;
		checks++;
		if (cpu_do !== exp) begin
			$display("MISMATCH cpu_do (%s): got %h, expected %h", name, cpu_do, exp);
			mismatches++;
		end
		@(negedge clk);
		cpu_addr = ppu_pkg::REG_STAT;
	endtask

	// n line starts seen as mode 2 beginning again
	task automatic wait_lines(input int n);
		repeat (n) begin
			@(negedge clk);
			while (mode == 2'd2) @(negedge clk);
			while (mode != 2'd2) @(negedge clk);
		end
	endtask

	// through vblank into line 0 of the next frame
	task automatic wait_frame();
		while (mode != 2'd1) @(negedge clk);
		while (mode == 2'd1) @(negedge clk);
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = mismatches + dut.u_assert.fail_count - seen_errors;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errs);
		end
		seen_errors = mismatches + dut.u_assert.fail_count;
	endtask

	initial begin
		logic [7:0] val;
		logic [7:0] lyc_val;
		logic [7:0] lcdc_val;
		clk = 1'b0;
		reset = 1'b1;
		cpu_sel_reg = 1'b0;
		cpu_wr = 1'b0;
		cpu_addr = ppu_pkg::REG_STAT;
		cpu_di = 8'h00;
		void'($urandom(62));
		repeat (3) @(negedge clk);
		reset = 1'b0;

		// --------------------
		// registers with the lcd still off
		check_reg(ppu_pkg::REG_LCDC, 8'h00, "LCDC");
		// bit 7 set, LY equals LYC, mode 0
		check_reg(ppu_pkg::REG_STAT, 8'h84, "STAT");
		check_reg(ppu_pkg::REG_SCY, 8'h00, "SCY");
		check_reg(ppu_pkg::REG_SCX, 8'h00, "SCX");
		check_reg(ppu_pkg::REG_LY, 8'h00, "LY");
		check_reg(ppu_pkg::REG_LYC, 8'h00, "LYC");
		check_reg(ppu_pkg::REG_BGP, 8'hfc, "BGP");
		val = 8'($urandom);
		write_reg(ppu_pkg::REG_SCY, val);
		check_reg(ppu_pkg::REG_SCY, val, "SCY");
		val = 8'($urandom);
		write_reg(ppu_pkg::REG_SCX, val);
		check_reg(ppu_pkg::REG_SCX, val, "SCX");
		val = 8'($urandom);
		write_reg(ppu_pkg::REG_BGP, val);
		check_reg(ppu_pkg::REG_BGP, val, "BGP");
		lyc_val = 8'($urandom);
		write_reg(ppu_pkg::REG_LYC, lyc_val);
		check_reg(ppu_pkg::REG_LYC, lyc_val, "LYC");
		// only the enable bits stick
		write_reg(ppu_pkg::REG_STAT, 8'hff);
		check_reg(ppu_pkg::REG_STAT, {1'b1, 4'hf, lyc_val == 8'h00, 2'b00}, "STAT");
		write_reg(ppu_pkg::REG_LY, 8'h55);
		check_reg(ppu_pkg::REG_LY, 8'h00, "LY");
		write_reg(ppu_pkg::REG_LCDC, 8'h15);
		check_reg(ppu_pkg::REG_LCDC, 8'h15, "LCDC");
		write_reg(8'h46, 8'h12);
		check_reg(8'h46, 8'hff, "unmapped 0x46");
		check_reg(8'h50, 8'hff, "unmapped 0x50");
		end_test("registers");

		// --------------------
		// all interrupt sources enabled with the display off for two line times
		write_reg(ppu_pkg::REG_STAT, 8'h78);
		write_reg(ppu_pkg::REG_LCDC, 8'h11);
		repeat (2 * 456) @(negedge clk);
		end_test("lcd off");

		// --------------------
		// one full frame with only the oam and hblank sources enabled
		write_reg(ppu_pkg::REG_STAT, 8'h28);
		write_reg(ppu_pkg::REG_LYC, 8'h00);
		write_reg(ppu_pkg::REG_LCDC, 8'h91);
		wait_frame();
		end_test("frame timing");

		// --------------------
		// both data modes and both maps with random scroll and palette
		for (int i = 0; i < 5; i++) begin
			write_reg(ppu_pkg::REG_LCDC, 8'h00);
			write_reg(ppu_pkg::REG_SCX, 8'($urandom));
			write_reg(ppu_pkg::REG_SCY, 8'($urandom));
			write_reg(ppu_pkg::REG_BGP, 8'($urandom));
			lcdc_val = 8'h81;
			if (i[0]) lcdc_val = lcdc_val | 8'h10;
			if (i[1]) lcdc_val = lcdc_val | 8'h08;
			// last pass runs with the background disabled
			if (i == 4) lcdc_val = 8'h90;
			write_reg(ppu_pkg::REG_LCDC, lcdc_val);
			wait_lines(3);
			// scroll written during mode 3 takes effect from the next line
			while (mode != 2'd3) @(negedge clk);
			write_reg(ppu_pkg::REG_SCX, 8'($urandom));
			write_reg(ppu_pkg::REG_SCY, 8'($urandom));
			wait_lines(3);
		end
		end_test("background pixels");

		// --------------------
		// lyc and vblank sources alone over a full frame
		write_reg(ppu_pkg::REG_LCDC, 8'h00);
		write_reg(ppu_pkg::REG_LYC, 8'($urandom % 144));
		write_reg(ppu_pkg::REG_STAT, 8'h50);
		write_reg(ppu_pkg::REG_LCDC, 8'h91);
		wait_frame();
		end_test("stat interrupts");

		$display("register checks %0d, mismatches %0d, assertion failures %0d",
			checks, mismatches, dut.u_assert.fail_count);
		if (mismatches == 0 && dut.u_assert.fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
